/* Bender.yml */
package:
  name: queue_manager

sources:
  - hdl/qm_pkg.sv
  - hdl/table_port_if.sv
  - hdl/queue_table.sv
  - hdl/sync_fifo.sv
  - hdl/state_fetcher.sv
  - hdl/tail_updater.sv
  - hdl/queue_manager.sv
  - target: simulation
    files:
      - tb/queue_manager_tb.sv

/* all.f */
hdl/qm_pkg.sv
hdl/table_port_if.sv
hdl/queue_table.sv
hdl/sync_fifo.sv
hdl/state_fetcher.sv
hdl/tail_updater.sv
hdl/queue_manager.sv
tb/queue_manager_tb.sv

/* hdl/qm_pkg.sv */
package qm_pkg;

    ////////////////////////////////
    // sizes
    ////////////////////////////////

    localparam int NB_QUEUES       = 8;
    localparam int QUEUE_ID_WIDTH  = 3;
    localparam int RB_AWIDTH       = 10;
    localparam int MAX_PKT_SIZE    = 16;
    localparam int PKT_SIZE_WIDTH  = 5;
    localparam int BUF_ADDR_WIDTH  = 64;
    localparam int EXTRA_META_BITS = 8;

    localparam int FETCH_FIFO_DEPTH = 4;
    localparam int OUT_FIFO_DEPTH   = 16;
    // updater stops popping above this output occupancy
    localparam int OUT_ALMOST_FULL  = OUT_FIFO_DEPTH - 4;
    // enough entries to cover every packet that may hold a stale tail
    localparam int TAIL_HISTORY_DEPTH = FETCH_FIFO_DEPTH + 3;

    ////////////////////////////////
    // types
    ////////////////////////////////

    typedef logic [QUEUE_ID_WIDTH-1:0] queue_id_t;
    typedef logic [RB_AWIDTH-1:0]      rb_ptr_t;
    typedef logic [BUF_ADDR_WIDTH-1:0] buf_addr_t;

    typedef struct packed {
        rb_ptr_t   head;
        rb_ptr_t   tail;
        buf_addr_t buf_addr;
    } queue_state_t;

    typedef struct packed {
        logic [PKT_SIZE_WIDTH-1:0]  size;       // in flits
        logic [EXTRA_META_BITS-1:0] meta_extra;
        logic                       pass_through;
    } pkt_meta_t;

    typedef struct packed {
        queue_state_t state;
        queue_id_t    queue;
        pkt_meta_t    meta;
    } fetched_t;

    typedef struct packed {
        queue_state_t               state;
        logic [EXTRA_META_BITS-1:0] meta_extra;
    } out_entry_t;

endpackage

/* hdl/queue_manager.sv */
`timescale 1ns/1ps

module queue_manager
    import qm_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    // packet descriptors in
    input  queue_id_t                  in_queue_id,
    input  logic [PKT_SIZE_WIDTH-1:0]  in_size,
    input  logic [EXTRA_META_BITS-1:0] in_meta_extra,
    input  logic                       in_pass_through,
    input  logic                       in_meta_valid,
    output logic                       in_meta_ready,

    // queue state out
    output rb_ptr_t                    out_head,
    output rb_ptr_t                    out_tail,
    output buf_addr_t                  out_buf_addr,
    output logic [EXTRA_META_BITS-1:0] out_meta_extra,
    output logic                       out_meta_valid,
    input  logic                       out_meta_ready,

    // host writes, only while no packet is in flight
    input  queue_id_t                  cfg_queue,
    input  buf_addr_t                  cfg_data,
    input  logic                       cfg_head_wr,
    input  logic                       cfg_tail_wr,
    input  logic                       cfg_addr_wr,

    input  logic [RB_AWIDTH:0]         rb_size
);

    table_port_if #(.data_t(rb_ptr_t))   tails_a ();
    table_port_if #(.data_t(rb_ptr_t))   tails_b ();
    table_port_if #(.data_t(rb_ptr_t))   heads_a ();
    table_port_if #(.data_t(rb_ptr_t))   heads_b ();
    table_port_if #(.data_t(buf_addr_t)) addrs_a ();
    table_port_if #(.data_t(buf_addr_t)) addrs_b ();

    pkt_meta_t  in_meta;
    fetched_t   fetch_in;
    logic       fetch_in_valid;
    fetched_t   fetch_out;
    logic       fetch_out_valid;
    logic       fetch_out_ready;
    logic [$clog2(FETCH_FIFO_DEPTH+1)-1:0] fetch_occupancy;
    out_entry_t out_in;
    logic       out_in_valid;
    out_entry_t out_data;
    logic [$clog2(OUT_FIFO_DEPTH+1)-1:0]   out_occupancy;
    logic       tail_wr;
    queue_id_t  tail_wr_queue;
    rb_ptr_t    tail_wr_value;

    assign in_meta.size         = in_size;
    assign in_meta.meta_extra   = in_meta_extra;
    assign in_meta.pass_through = in_pass_through;

    assign out_head       = out_data.state.head;
    assign out_tail       = out_data.state.tail;
    assign out_buf_addr   = out_data.state.buf_addr;
    assign out_meta_extra = out_data.meta_extra;

    ////////////////////////////////
    // host side of the tables
    ////////////////////////////////

    assign tails_b.addr    = cfg_queue;
    assign tails_b.rd_en   = 1'b0;
    assign tails_b.wr_en   = cfg_tail_wr;
    assign tails_b.wr_data = rb_ptr_t'(cfg_data);
    assign heads_b.addr    = cfg_queue;
    assign heads_b.rd_en   = 1'b0;
    assign heads_b.wr_en   = cfg_head_wr;
    assign heads_b.wr_data = rb_ptr_t'(cfg_data);
    assign addrs_b.addr    = cfg_queue;
    assign addrs_b.rd_en   = 1'b0;
    assign addrs_b.wr_en   = cfg_addr_wr;
    assign addrs_b.wr_data = cfg_data;

    queue_table #(.data_t(rb_ptr_t)) i_tails (
        .clk(clk), .port_a(tails_a), .port_b(tails_b)
    );
    queue_table #(.data_t(rb_ptr_t)) i_heads (
        .clk(clk), .port_a(heads_a), .port_b(heads_b)
    );
    queue_table #(.data_t(buf_addr_t)) i_addrs (
        .clk(clk), .port_a(addrs_a), .port_b(addrs_b)
    );

    ////////////////////////////////
    // pipeline
    ////////////////////////////////

    state_fetcher i_fetcher (
        .clk(clk), .rst(rst),
        .in_queue_id(in_queue_id), .in_meta(in_meta),
        .in_meta_valid(in_meta_valid), .in_meta_ready(in_meta_ready),
        .tails_a(tails_a), .heads_a(heads_a), .addrs_a(addrs_a),
        .tail_wr(tail_wr), .tail_wr_queue(tail_wr_queue), .tail_wr_value(tail_wr_value),
        .fetch_occupancy(fetch_occupancy),
        .fetched(fetch_in), .fetched_valid(fetch_in_valid)
    );

    // space is guaranteed by the fetcher, so in_ready is not needed
    sync_fifo #(.item_t(fetched_t), .DEPTH(FETCH_FIFO_DEPTH)) i_fetch_fifo (
        .clk(clk), .rst(rst),
        .in_data(fetch_in), .in_valid(fetch_in_valid), .in_ready(),
        .out_data(fetch_out), .out_valid(fetch_out_valid), .out_ready(fetch_out_ready),
        .occupancy(fetch_occupancy)
    );

    tail_updater i_updater (
        .clk(clk), .rst(rst), .rb_size(rb_size),
        .fetched(fetch_out), .fetched_valid(fetch_out_valid),
        .fetched_ready(fetch_out_ready), .out_occupancy(out_occupancy),
        .out_entry(out_in), .out_entry_valid(out_in_valid),
        .tail_wr(tail_wr), .tail_wr_queue(tail_wr_queue), .tail_wr_value(tail_wr_value)
    );

    sync_fifo #(.item_t(out_entry_t), .DEPTH(OUT_FIFO_DEPTH)) i_out_fifo (
        .clk(clk), .rst(rst),
        .in_data(out_in), .in_valid(out_in_valid), .in_ready(),
        .out_data(out_data), .out_valid(out_meta_valid), .out_ready(out_meta_ready),
        .occupancy(out_occupancy)
    );

endmodule

/* hdl/queue_table.sv */
`timescale 1ns/1ps

module queue_table
    import qm_pkg::*;
#(
    parameter type data_t = logic
)(
    input logic       clk,
    table_port_if.tbl port_a,
    table_port_if.tbl port_b
);

    data_t mem [NB_QUEUES];

    data_t a_data_q;
    data_t b_data_q;
    logic  a_rd_q;
    logic  b_rd_q;

    // port b is written last, so it wins on a same-address clash
    always_ff @(posedge clk) begin
        if (port_a.wr_en) begin
            mem[port_a.addr] <= port_a.wr_data;
        end
        if (port_b.wr_en) begin
            mem[port_b.addr] <= port_b.wr_data;
        end
    end

    // two register stages per read port
    always_ff @(posedge clk) begin
        a_rd_q <= port_a.rd_en;
        b_rd_q <= port_b.rd_en;
        if (port_a.rd_en) begin
            a_data_q <= mem[port_a.addr];
        end
        if (port_b.rd_en) begin
            b_data_q <= mem[port_b.addr];
        end
        if (a_rd_q) begin
            port_a.rd_data <= a_data_q;
        end
        if (b_rd_q) begin
            port_b.rd_data <= b_data_q;
        end
    end

endmodule

/* hdl/state_fetcher.sv */
`timescale 1ns/1ps

module state_fetcher
    import qm_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  queue_id_t in_queue_id,
    input  pkt_meta_t in_meta,
    input  logic      in_meta_valid,
    output logic      in_meta_ready,

    table_port_if.owner tails_a,
    table_port_if.owner heads_a,
    table_port_if.owner addrs_a,

    input  logic      tail_wr,
    input  queue_id_t tail_wr_queue,
    input  rb_ptr_t   tail_wr_value,

    input  logic [$clog2(FETCH_FIFO_DEPTH+1)-1:0] fetch_occupancy,

    output fetched_t  fetched,
    output logic      fetched_valid
);

    logic      accept;
    logic      valid_q [2];
    queue_id_t queue_q [2];
    pkt_meta_t meta_q  [2];

    // leave room for everything still in the read pipeline
    assign in_meta_ready = !tail_wr && (fetch_occupancy < FETCH_FIFO_DEPTH - 3);
    assign accept        = in_meta_valid && in_meta_ready;

    ////////////////////////////////
    // table port a
    ////////////////////////////////

    // the id is presented while accepting, the table samples it on the next edge.
    // a tail write owns the tails port, input is held off in that cycle
    assign tails_a.addr    = tail_wr ? tail_wr_queue : in_queue_id;
    assign tails_a.rd_en   = accept;
    assign tails_a.wr_en   = tail_wr;
    assign tails_a.wr_data = tail_wr_value;

    assign heads_a.addr    = in_queue_id;
    assign heads_a.rd_en   = accept;
    assign heads_a.wr_en   = 1'b0;
    assign heads_a.wr_data = '0;

    assign addrs_a.addr    = in_queue_id;
    assign addrs_a.rd_en   = accept;
    assign addrs_a.wr_en   = 1'b0;
    assign addrs_a.wr_data = '0;

    ////////////////////////////////
    // metadata delay
    ////////////////////////////////

    always_ff @(posedge clk) begin
        queue_q[0] <= in_queue_id;
        meta_q[0]  <= in_meta;
        queue_q[1] <= queue_q[0];
        meta_q[1]  <= meta_q[0];
        // read data is valid while valid_q[1] is high
        if (valid_q[1]) begin
            fetched.state.head     <= heads_a.rd_data;
            fetched.state.tail     <= tails_a.rd_data;
            fetched.state.buf_addr <= addrs_a.rd_data;
            fetched.queue          <= queue_q[1];
            fetched.meta           <= meta_q[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q[0]    <= 1'b0;
            valid_q[1]    <= 1'b0;
            fetched_valid <= 1'b0;
        end else begin
            valid_q[0]    <= accept;
            valid_q[1]    <= valid_q[0];
            fetched_valid <= valid_q[1];
        end
    end

endmodule

/* hdl/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 4
)(
    input  logic                       clk,
    input  logic                       rst,
    input  item_t                      in_data,
    input  logic                       in_valid,
    output logic                       in_ready,
    output item_t                      out_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [$clog2(DEPTH+1)-1:0] occupancy
);

    localparam int PTR_WIDTH = $clog2(DEPTH);

    item_t mem [DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic                 push;
    logic                 pop;

    assign in_ready  = occupancy < DEPTH;
    assign out_valid = occupancy != 0;
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    ////////////////////////////////
    // pointers and count
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                occupancy <= occupancy + 1'b1;
            end else if (pop && !push) begin
                occupancy <= occupancy - 1'b1;
            end
        end
    end

endmodule

/* hdl/table_port_if.sv */
`timescale 1ns/1ps

// one port of a queue table
interface table_port_if
    import qm_pkg::*;
#(
    parameter type data_t = logic
);

    queue_id_t addr;
    logic      rd_en;
    logic      wr_en;
    data_t     wr_data;
    // valid two cycles after rd_en, held until the next read
    data_t     rd_data;

    modport owner (
        output addr, rd_en, wr_en, wr_data,
        input  rd_data
    );

    // "table" is a reserved word, hence tbl
    modport tbl (
        input  addr, rd_en, wr_en, wr_data,
        output rd_data
    );

endinterface

/* hdl/tail_updater.sv */
`timescale 1ns/1ps

module tail_updater
    import qm_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic [RB_AWIDTH:0]   rb_size,

    input  fetched_t             fetched,
    input  logic                 fetched_valid,
    output logic                 fetched_ready,

    input  logic [$clog2(OUT_FIFO_DEPTH+1)-1:0] out_occupancy,

    output out_entry_t           out_entry,
    output logic                 out_entry_valid,

    output logic                 tail_wr,
    output queue_id_t            tail_wr_queue,
    output rb_ptr_t              tail_wr_value
);

    rb_ptr_t rb_mask;

    // index 0 is the newest update
    logic [TAIL_HISTORY_DEPTH-1:0] hist_valid;
    queue_id_t                     hist_queue [TAIL_HISTORY_DEPTH];
    rb_ptr_t                       hist_tail  [TAIL_HISTORY_DEPTH];

    logic    pop;
    rb_ptr_t fwd_tail;
    rb_ptr_t adv_tail;
    rb_ptr_t new_tail;

    assign fetched_ready = out_occupancy <= OUT_ALMOST_FULL;
    assign pop           = fetched_valid && fetched_ready;

    always_ff @(posedge clk) begin
        rb_mask <= rb_ptr_t'(rb_size - 1'b1);
    end

    ////////////////////////////////
    // tail forwarding
    ////////////////////////////////

    // walk from oldest to newest so the newest match wins
    always_comb begin
        fwd_tail = fetched.state.tail;
        for (int i = TAIL_HISTORY_DEPTH - 1; i >= 0; i--) begin
            if (hist_valid[i] && hist_queue[i] == fetched.queue) begin
                fwd_tail = hist_tail[i];
            end
        end
    end

    assign adv_tail = (fwd_tail + rb_ptr_t'(fetched.meta.size)) & rb_mask;
    // pass-through keeps the tail where it is
    assign new_tail = fetched.meta.pass_through ? fwd_tail : adv_tail;

    ////////////////////////////////
    // outputs and history
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (pop) begin
            out_entry.state.head     <= fetched.state.head;
            out_entry.state.tail     <= fwd_tail;
            out_entry.state.buf_addr <= fetched.state.buf_addr;
            out_entry.meta_extra     <= fetched.meta.meta_extra;
            tail_wr_queue            <= fetched.queue;
            tail_wr_value            <= new_tail;
            hist_queue[0]            <= fetched.queue;
            hist_tail[0]             <= new_tail;
            for (int i = 1; i < TAIL_HISTORY_DEPTH; i++) begin
                hist_queue[i] <= hist_queue[i-1];
                hist_tail[i]  <= hist_tail[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_entry_valid <= 1'b0;
            tail_wr         <= 1'b0;
            hist_valid      <= '0;
        end else begin
            out_entry_valid <= pop;
            tail_wr         <= pop && !fetched.meta.pass_through;
            if (pop) begin
                hist_valid <= {hist_valid[TAIL_HISTORY_DEPTH-2:0], 1'b1};
            end
        end
    end

endmodule

/* tb/qm_testdata.txt */
# ring <rb_size> | cfg <queue> <head> <tail> <buf_addr> | rst <name>
# pkt <name> <queue> <size> <pass_through> <extra> <exp_head> <exp_tail> <exp_buf_addr>, all hex
ring 40
rst after_reset
cfg 0 003 010 0000000080001000
cfg 1 000 03a 00000000a0002000
cfg 2 011 020 00000000c0003000
cfg 5 02f 000 ffff000012340000
pkt q0_first 0 4 0 a1 003 010 0000000080001000
pkt q0_b2b_1 0 10 0 a2 003 014 0000000080001000
pkt q0_b2b_2 0 8 0 a3 003 024 0000000080001000
pkt q1_first 1 6 0 b1 000 03a 00000000a0002000
pkt q1_wrap 1 5 0 b2 000 000 00000000a0002000
pkt q1_pass 1 3 1 b3 000 005 00000000a0002000
pkt q1_after_pass 1 2 0 b4 000 005 00000000a0002000
pkt q2_il_1 2 7 0 c1 011 020 00000000c0003000
pkt q5_il_1 5 c 0 d1 02f 000 ffff000012340000
pkt q2_il_2 2 9 0 c2 011 027 00000000c0003000
pkt q0_il 0 1 0 a4 003 02c 0000000080001000
pkt q5_il_2 5 10 0 d2 02f 00c ffff000012340000
pkt q2_il_pass 2 1 1 c3 011 030 00000000c0003000
pkt q2_il_3 2 f 0 c4 011 030 00000000c0003000
pkt q2_il_wrap 2 3 0 c5 011 03f 00000000c0003000
pkt q5_il_3 5 4 0 d3 02f 01c ffff000012340000
rst mid_reset
cfg 3 001 03c 0000000100000000
pkt q3_after_rst 3 4 0 e1 001 03c 0000000100000000
pkt q3_next 3 4 0 e2 001 000 0000000100000000

/* tb/queue_manager_tb.sv */
`timescale 1ns/1ps

module queue_manager_tb
    import qm_pkg::*;
();

    typedef logic [8*24-1:0] name_t;
    typedef enum logic [1:0] {OP_RING, OP_CFG, OP_PKT, OP_RST} op_kind_t;

    // one line of the testdata file
    typedef struct packed {
        op_kind_t                   kind;
        name_t                      name;
        queue_id_t                  queue;
        logic [PKT_SIZE_WIDTH-1:0]  size;
        logic                       pass_through;
        logic [EXTRA_META_BITS-1:0] extra;
        rb_ptr_t                    head;
        rb_ptr_t                    tail;
        buf_addr_t                  addr;
    } test_op_t;

    logic                       clk;
    logic                       rst;
    queue_id_t                  in_queue_id;
    logic [PKT_SIZE_WIDTH-1:0]  in_size;
    logic [EXTRA_META_BITS-1:0] in_meta_extra;
    logic                       in_pass_through;
    logic                       in_meta_valid;
    logic                       in_meta_ready;
    rb_ptr_t                    out_head;
    rb_ptr_t                    out_tail;
    buf_addr_t                  out_buf_addr;
    logic [EXTRA_META_BITS-1:0] out_meta_extra;
    logic                       out_meta_valid;
    logic                       out_meta_ready;
    queue_id_t                  cfg_queue;
    buf_addr_t                  cfg_data;
    logic                       cfg_head_wr;
    logic                       cfg_tail_wr;
    logic                       cfg_addr_wr;
    logic [RB_AWIDTH:0]         rb_size;

    test_op_t    ops [64];
    test_op_t    exp_q [$];
    int          n_ops;
    int          pass_count;
    int          fail_count;
    logic        parse_done;
    logic [31:0] rnd;

    queue_manager i_dut (
        .clk(clk), .rst(rst),
        .in_queue_id(in_queue_id), .in_size(in_size), .in_meta_extra(in_meta_extra),
        .in_pass_through(in_pass_through), .in_meta_valid(in_meta_valid),
        .in_meta_ready(in_meta_ready),
        .out_head(out_head), .out_tail(out_tail), .out_buf_addr(out_buf_addr),
        .out_meta_extra(out_meta_extra), .out_meta_valid(out_meta_valid),
        .out_meta_ready(out_meta_ready),
        .cfg_queue(cfg_queue), .cfg_data(cfg_data), .cfg_head_wr(cfg_head_wr),
        .cfg_tail_wr(cfg_tail_wr), .cfg_addr_wr(cfg_addr_wr), .rb_size(rb_size)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    ////////////////////////////////
    // testdata parsing
    ////////////////////////////////

    task automatic read_testdata();
        int            fd;
        int            rc;
        name_t         word;
        name_t         nm;
        logic [1023:0] rest;
        logic [63:0]   f0, f1, f2, f3, f4, f5, f6;
        test_op_t      op;
        fd = $fopen("tb/qm_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/qm_testdata.txt");
            return;
        end
        while (n_ops < 64 && $fscanf(fd, "%s", word) == 1) begin
            op = '0;
            if (word == name_t'("#")) begin
                rc = $fgets(rest, fd);
                continue;
            end
            case (word)
                name_t'("ring"): begin
                    rc      = $fscanf(fd, "%h", f0) - 1;
                    op.kind = OP_RING;
                    op.addr = f0;
                end
                name_t'("cfg"): begin
                    rc       = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3) - 4;
                    op.kind  = OP_CFG;
                    op.queue = f0[QUEUE_ID_WIDTH-1:0];
                    op.head  = f1[RB_AWIDTH-1:0];
                    op.tail  = f2[RB_AWIDTH-1:0];
                    op.addr  = f3;
                end
                name_t'("pkt"): begin
                    rc = $fscanf(fd, "%s %h %h %h %h %h %h %h",
                                 nm, f0, f1, f2, f3, f4, f5, f6) - 8;
                    op.kind         = OP_PKT;
                    op.name         = nm;
                    op.queue        = f0[QUEUE_ID_WIDTH-1:0];
                    op.size         = f1[PKT_SIZE_WIDTH-1:0];
                    op.pass_through = f2[0];
                    op.extra        = f3[EXTRA_META_BITS-1:0];
                    op.head         = f4[RB_AWIDTH-1:0];
                    op.tail         = f5[RB_AWIDTH-1:0];
                    op.addr         = f6;
                end
                name_t'("rst"): begin
                    rc      = $fscanf(fd, "%s", nm) - 1;
                    op.kind = OP_RST;
                    op.name = nm;
                end
                default: rc = -1;
            endcase
            if (rc != 0) begin
                $display("malformed or unknown line in testdata after entry %0d", n_ops);
                fail_count++;
            end else begin
                ops[n_ops] = op;
                n_ops++;
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////
    // driving
    ////////////////////////////////

    // every task starts and ends 1 ns after a rising edge
    task automatic apply_reset(input bit check, input name_t name);
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        if (check) begin
            assert (in_meta_ready === 1'b1 && out_meta_valid === 1'b0) begin
                pass_count++;
                $display("ok   %0s", name);
            end else begin
                fail_count++;
                $display("Fail %0s: expected ready 1 valid 0, actual ready %b valid %b",
                         name, in_meta_ready, out_meta_valid);
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic write_config(input test_op_t op);
        cfg_queue   = op.queue;
        cfg_data    = buf_addr_t'(op.head);
        cfg_head_wr = 1'b1;
        @(posedge clk);
        #1;
        cfg_head_wr = 1'b0;
        cfg_data    = buf_addr_t'(op.tail);
        cfg_tail_wr = 1'b1;
        @(posedge clk);
        #1;
        cfg_tail_wr = 1'b0;
        cfg_data    = op.addr;
        cfg_addr_wr = 1'b1;
        @(posedge clk);
        #1;
        cfg_addr_wr = 1'b0;
    endtask

    // valid stays high, so packets in a row go back to back
    task automatic send_packet(input test_op_t op);
        logic taken;
        exp_q.push_back(op);
        in_queue_id     = op.queue;
        in_size         = op.size;
        in_meta_extra   = op.extra;
        in_pass_through = op.pass_through;
        in_meta_valid   = 1'b1;
        do begin
            @(negedge clk);
            taken = in_meta_ready;
            @(posedge clk);
            #1;
        end while (!taken);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    ////////////////////////////////
    // checking
    ////////////////////////////////

    task automatic check_output();
        test_op_t exp;
        assert (exp_q.size() != 0) else begin
            fail_count++;
            $display("an output appeared while no packet was pending");
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            assert ({out_head, out_tail, out_buf_addr, out_meta_extra}
                    == {exp.head, exp.tail, exp.addr, exp.extra}) begin
                pass_count++;
                $display("ok   %0s", exp.name);
            end else begin
                fail_count++;
                $display("Fail %0s: expected %h %h %h %h, actual %h %h %h %h", exp.name,
                         exp.head, exp.tail, exp.addr, exp.extra,
                         out_head, out_tail, out_buf_addr, out_meta_extra);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // random back-pressure, ready about three cycles in four
    initial begin
        rnd            = 32'h71b7;
        out_meta_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rnd            = xorshift32(rnd);
            out_meta_ready = rnd[1:0] != 2'b00;
        end
    end

    // a transfer seen at the falling edge completes on the next rising edge
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && out_meta_valid === 1'b1 && out_meta_ready) begin
                check_output();
            end
        end
    end

    initial begin
        wait (parse_done === 1'b1);
        repeat (n_ops * 60) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", n_ops * 60);
        $display("Something failed");
        $finish;
    end

    initial begin
        rst             = 1'b1;
        in_queue_id     = '0;
        in_size         = '0;
        in_meta_extra   = '0;
        in_pass_through = 1'b0;
        in_meta_valid   = 1'b0;
        cfg_queue       = '0;
        cfg_data        = '0;
        cfg_head_wr     = 1'b0;
        cfg_tail_wr     = 1'b0;
        cfg_addr_wr     = 1'b0;
        rb_size         = '0;
        n_ops           = 0;
        pass_count      = 0;
        fail_count      = 0;
        parse_done      = 1'b0;
        read_testdata();
        parse_done = 1'b1;
        if (n_ops == 0) begin
            $display("no test lines could be read");
            $display("Something failed");
            $finish;
        end else begin
            apply_reset(1'b0, '0);
            for (int i = 0; i < n_ops; i++) begin
                if (ops[i].kind == OP_PKT) begin
                    send_packet(ops[i]);
                end else begin
                    in_meta_valid = 1'b0;
                    wait_drain();
                    case (ops[i].kind)
                        OP_RING: begin
                            rb_size = ops[i].addr[RB_AWIDTH:0];
                            @(posedge clk);
                            #1;
                        end
                        OP_CFG:  write_config(ops[i]);
                        default: apply_reset(1'b1, ops[i].name);
                    endcase
                end
            end
            in_meta_valid = 1'b0;
            wait_drain();
            // idle margin to catch stray outputs
            repeat (20) @(posedge clk);
            $display("%0d checks passed, %0d failed", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule
